// ==== design/capture_pkg.sv ====
`default_nettype none

package capture_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int WB_DATA_W   = 16;
  localparam int WB_ADR_W    = 16;
  localparam int WB_SEL_W    = 2;
  localparam int COUNTER_W   = 64;
  localparam int FRAME_LEN_W = 12;
  localparam int SLOT_DATA_W = 32;

  localparam logic [7:0] GMII_SFD = 8'hD5;

  // rx region words in front of the slot memory
  localparam int SLOT_BASE_WORDS = 4;

  // --------------------------------------------------------------------------
  // address map
  // --------------------------------------------------------------------------
  // address bits 15:13
  typedef enum logic [2:0] {
    REGION_GLOBAL = 3'd0,
    REGION_RX     = 3'd4
  } region_e;

  // address bits 3:1 of the global region
  typedef enum logic [2:0] {
    GCFG_STATUS = 3'd0,
    GCFG_CNT0   = 3'd2,
    GCFG_CNT1   = 3'd3,
    GCFG_CNT2   = 3'd4,
    GCFG_CNT3   = 3'd5
  } gcfg_reg_e;

  // halfword index, address bits 12:1 of the rx region
  typedef enum logic [11:0] {
    RX_TS0        = 12'd0,
    RX_TS1        = 12'd1,
    RX_TS2        = 12'd2,
    RX_TS3        = 12'd3,
    RX_LEN        = 12'd6,
    RX_SLOT_FIRST = 12'd8
  } rx_reg_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_DATA,
    RX_HOLD
  } rx_state_e;

endpackage

`default_nettype wire

// ==== design/wall_clock.sv ====
`default_nettype none

module wall_clock import capture_pkg::*; (
  input  logic                 clk_125,
  input  logic                 core_rst_n,
  input  logic                 wr_i,
  input  logic [1:0]           wr_word_i,
  input  logic [WB_SEL_W-1:0]  wr_sel_i,
  input  logic [WB_DATA_W-1:0] wr_data_i,
  output logic [COUNTER_W-1:0] count_o
);

  logic [COUNTER_W-1:0] count_q;
  logic [COUNTER_W-1:0] wr_mask;
  logic [COUNTER_W-1:0] wr_val;

  // sel[0] -> bits 15:8, sel[1] -> bits 7:0 of the halfword
  always_comb begin
    wr_mask = '0;
    wr_val  = '0;
    if (wr_i) begin
      wr_mask[wr_word_i*WB_DATA_W +: WB_DATA_W] = {{8{wr_sel_i[0]}}, {8{wr_sel_i[1]}}};
      wr_val[wr_word_i*WB_DATA_W +: WB_DATA_W]  = wr_data_i;
    end
  end

  // unwritten bits keep counting
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= ((count_q + 1'b1) & ~wr_mask) | (wr_val & wr_mask);
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

// ==== design/eth_rx_slot.sv ====
`default_nettype none

module eth_rx_slot import capture_pkg::*; #(
  parameter int SLOT_ADDR_W = 11
) (
  input  logic                   clk_125,
  input  logic                   core_rst_n,
  input  logic [7:0]             gmii_rxd_i,
  input  logic                   gmii_rx_dv_i,
  input  logic                   slot_busy_i,
  input  logic [COUNTER_W-1:0]   now_i,
  output logic [SLOT_ADDR_W-1:0] ram_addr_o,
  output logic [SLOT_DATA_W-1:0] ram_data_o,
  output logic [3:0]             ram_be_o,
  output logic                   ram_we_o,
  output logic                   frame_done_o,
  output logic [FRAME_LEN_W-1:0] frame_len_o,
  output logic [COUNTER_W-1:0]   timestamp_o
);

  rx_state_e              state_q;
  logic [FRAME_LEN_W-1:0] byte_cnt;
  logic [COUNTER_W-1:0]   ts_cap;
  logic                   sfd_hit;
  logic                   cnt_full;
  logic                   byte_wr_ok;
  logic                   frame_end;

  assign sfd_hit = (state_q == RX_IDLE || state_q == RX_PREAMBLE) && gmii_rx_dv_i &&
                   !slot_busy_i && (gmii_rxd_i == GMII_SFD);

  // length saturates, slot overflow bytes are only counted
  assign cnt_full   = &byte_cnt;
  assign byte_wr_ok = !cnt_full &&
                      (32'(byte_cnt[FRAME_LEN_W-1:2]) < (32'd1 << SLOT_ADDR_W));
  assign frame_end  = (state_q == RX_DATA) && !gmii_rx_dv_i;

  // --------------------------------------------------------------------------
  // receive FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state_q      <= RX_IDLE;
      byte_cnt     <= '0;
      ram_we_o     <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      ram_we_o     <= 1'b0;
      frame_done_o <= 1'b0;
      case (state_q)
        RX_IDLE, RX_PREAMBLE: begin
          if (!gmii_rx_dv_i) begin
            state_q <= RX_IDLE;
          end else if (slot_busy_i) begin
            // slot still owned by host, drop whole frame
            state_q <= RX_HOLD;
          end else if (sfd_hit) begin
            state_q  <= RX_DATA;
            byte_cnt <= '0;
          end else begin
            state_q <= RX_PREAMBLE;
          end
        end
        RX_DATA: begin
          if (gmii_rx_dv_i) begin
            ram_we_o <= byte_wr_ok;
            if (!cnt_full) begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end else begin
            frame_done_o <= 1'b1;
            state_q      <= RX_IDLE;
          end
        end
        RX_HOLD: begin
          if (!gmii_rx_dv_i) begin
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // byte lanes, length and timestamp
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sfd_hit) begin
      ts_cap <= now_i;
    end
    if (state_q == RX_DATA && gmii_rx_dv_i) begin
      ram_addr_o <= SLOT_ADDR_W'(byte_cnt[FRAME_LEN_W-1:2]);
      ram_data_o <= {4{gmii_rxd_i}};
      ram_be_o   <= 4'(4'b0001 << byte_cnt[1:0]);
    end
    // published together with frame_done_o
    if (frame_end) begin
      frame_len_o <= byte_cnt;
      timestamp_o <= ts_cap;
    end
  end

endmodule

`default_nettype wire

// ==== design/slot_ram.sv ====
`default_nettype none

module slot_ram #(
  parameter int SLOT_ADDR_W = 11
) (
  input  logic                   clk_125,
  // port A, host side
  input  logic [SLOT_ADDR_W-1:0] a_addr_i,
  input  logic [31:0]            a_data_i,
  input  logic [3:0]             a_be_i,
  input  logic                   a_we_i,
  output logic [31:0]            a_q_o,
  // port B, receiver side
  input  logic [SLOT_ADDR_W-1:0] b_addr_i,
  input  logic [31:0]            b_data_i,
  input  logic [3:0]             b_be_i,
  input  logic                   b_we_i,
  output logic [31:0]            b_q_o
);

  logic [31:0] mem [2**SLOT_ADDR_W];

  // byte writes on both ports, port B wins on a collision
  always_ff @(posedge clk_125) begin
    for (int i = 0; i < 4; i++) begin
      if (a_we_i && a_be_i[i]) begin
        mem[a_addr_i][8*i +: 8] <= a_data_i[8*i +: 8];
      end
      if (b_we_i && b_be_i[i]) begin
        mem[b_addr_i][8*i +: 8] <= b_data_i[8*i +: 8];
      end
    end
    // read old data
    a_q_o <= mem[a_addr_i];
    b_q_o <= mem[b_addr_i];
  end

endmodule

`default_nettype wire

// ==== design/host_bus_regs.sv ====
`default_nettype none

module host_bus_regs import capture_pkg::*; #(
  parameter int SLOT_ADDR_W = 11
) (
  input  logic                   clk_125,
  input  logic                   core_rst_n,
  input  logic [WB_ADR_W-1:0]    wb_adr_i,
  input  logic [WB_DATA_W-1:0]   wb_dat_i,
  input  logic [WB_SEL_W-1:0]    wb_sel_i,
  input  logic                   wb_we_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  output logic [WB_DATA_W-1:0]   wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   irq_o,
  output logic                   cnt_wr_o,
  output logic [1:0]             cnt_word_o,
  output logic [WB_SEL_W-1:0]    cnt_sel_o,
  output logic [WB_DATA_W-1:0]   cnt_data_o,
  output logic                   slot_busy_o,
  input  logic [COUNTER_W-1:0]   count_i,
  input  logic                   frame_done_i,
  input  logic [FRAME_LEN_W-1:0] frame_len_i,
  input  logic [COUNTER_W-1:0]   timestamp_i,
  output logic [SLOT_ADDR_W-1:0] ram_addr_o,
  output logic [SLOT_DATA_W-1:0] ram_data_o,
  output logic [3:0]             ram_be_o,
  output logic                   ram_we_o,
  input  logic [SLOT_DATA_W-1:0] ram_q_i
);

  logic                 req;
  logic                 req_new;
  logic [1:0]           rd_step;
  logic [3:0]           status_q;
  region_e              region;
  gcfg_reg_e            gcfg_idx;
  rx_reg_e              rx_idx;
  logic                 gcfg_hit;
  logic                 slot_hit;
  logic                 status_wr;
  logic [1:0]           cnt_word;
  logic [WB_DATA_W-1:0] reg_rdata;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  assign req     = wb_cyc_i && wb_stb_i;
  // first cycle of a request only
  assign req_new = req && !wb_ack_o && (rd_step == 2'd0);

  assign region   = region_e'(wb_adr_i[15:13]);
  assign gcfg_idx = gcfg_reg_e'(wb_adr_i[3:1]);
  assign rx_idx   = rx_reg_e'(wb_adr_i[12:1]);

  assign gcfg_hit = (region == REGION_GLOBAL) && (wb_adr_i[12:4] == '0);
  assign slot_hit = (region == REGION_RX) && (rx_idx >= RX_SLOT_FIRST);

  assign status_wr = req_new && wb_we_i && gcfg_hit && (gcfg_idx == GCFG_STATUS) &&
                     wb_sel_i[1];

  assign cnt_word   = 2'(wb_adr_i[3:1] - GCFG_CNT0);
  assign cnt_wr_o   = req_new && wb_we_i && gcfg_hit &&
                      (gcfg_idx inside {GCFG_CNT0, GCFG_CNT1, GCFG_CNT2, GCFG_CNT3});
  assign cnt_word_o = cnt_word;
  assign cnt_sel_o  = wb_sel_i;
  assign cnt_data_o = wb_dat_i;

  // register read mux, reserved and unmapped read zero
  always_comb begin
    reg_rdata = '0;
    case (region)
      REGION_GLOBAL: begin
        if (gcfg_hit) begin
          case (gcfg_idx)
            GCFG_STATUS: reg_rdata = WB_DATA_W'(status_q);
            GCFG_CNT0, GCFG_CNT1, GCFG_CNT2, GCFG_CNT3: begin
              reg_rdata = count_i[cnt_word*WB_DATA_W +: WB_DATA_W];
            end
            default: reg_rdata = '0;
          endcase
        end
      end
      REGION_RX: begin
        case (rx_idx)
          RX_TS0, RX_TS1, RX_TS2, RX_TS3: begin
            reg_rdata = timestamp_i[wb_adr_i[2:1]*WB_DATA_W +: WB_DATA_W];
          end
          RX_LEN:  reg_rdata = WB_DATA_W'(frame_len_i);
          default: reg_rdata = '0;
        endcase
      end
      default: reg_rdata = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // ack, slot read sequencer, status
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      wb_ack_o <= 1'b0;
      ram_we_o <= 1'b0;
      rd_step  <= 2'd0;
      status_q <= 4'b0000;
    end else begin
      wb_ack_o <= 1'b0;
      ram_we_o <= 1'b0;
      if (req_new) begin
        if (slot_hit && !wb_we_i) begin
          rd_step <= 2'd1;
        end else begin
          wb_ack_o <= 1'b1;
        end
        ram_we_o <= slot_hit && wb_we_i;
      end else if (rd_step == 2'd1) begin
        rd_step <= 2'd2;
      end else if (rd_step == 2'd2) begin
        // ram_q_i valid now
        rd_step  <= 2'd0;
        wb_ack_o <= 1'b1;
      end
      if (status_wr) begin
        status_q <= wb_dat_i[3:0];
      end
      // new frame must not be lost to a racing host write
      if (frame_done_i) begin
        status_q[0] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (req_new && !wb_we_i && !slot_hit) begin
      wb_dat_o <= reg_rdata;
    end else if (rd_step == 2'd2) begin
      wb_dat_o <= wb_adr_i[1] ? ram_q_i[31:16] : ram_q_i[15:0];
    end
    if (req_new && slot_hit) begin
      ram_addr_o <= SLOT_ADDR_W'(wb_adr_i[12:2] - 11'(SLOT_BASE_WORDS));
      ram_data_o <= {wb_dat_i, wb_dat_i};
      // adr[1] picks the upper halfword
      if (wb_adr_i[1]) begin
        ram_be_o <= {wb_sel_i[0], wb_sel_i[1], 2'b00};
      end else begin
        ram_be_o <= {2'b00, wb_sel_i[0], wb_sel_i[1]};
      end
    end
  end

  assign slot_busy_o = status_q[0];
  assign irq_o       = status_q[0];

endmodule

`default_nettype wire

// ==== design/capture_top.sv ====
`default_nettype none

module capture_top import capture_pkg::*; #(
  parameter int SLOT_ADDR_W = 11
) (
  input  logic                 clk_125,
  input  logic                 core_rst_n,
  input  logic [7:0]           gmii_rxd_i,
  input  logic                 gmii_rx_dv_i,
  input  logic [WB_ADR_W-1:0]  wb_adr_i,
  input  logic [WB_DATA_W-1:0] wb_dat_i,
  input  logic [WB_SEL_W-1:0]  wb_sel_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output logic [WB_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 irq_o
);

  logic [COUNTER_W-1:0]   count;
  logic                   cnt_wr;
  logic [1:0]             cnt_word;
  logic [WB_SEL_W-1:0]    cnt_sel;
  logic [WB_DATA_W-1:0]   cnt_data;
  logic                   slot_busy;
  logic                   frame_done;
  logic [FRAME_LEN_W-1:0] frame_len;
  logic [COUNTER_W-1:0]   timestamp;
  // slot port A, host
  logic [SLOT_ADDR_W-1:0] a_addr;
  logic [SLOT_DATA_W-1:0] a_data;
  logic [3:0]             a_be;
  logic                   a_we;
  logic [SLOT_DATA_W-1:0] a_q;
  // slot port B, receiver
  logic [SLOT_ADDR_W-1:0] b_addr;
  logic [SLOT_DATA_W-1:0] b_data;
  logic [3:0]             b_be;
  logic                   b_we;

  wall_clock i_wall_clock (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .wr_i       (cnt_wr),
    .wr_word_i  (cnt_word),
    .wr_sel_i   (cnt_sel),
    .wr_data_i  (cnt_data),
    .count_o    (count)
  );

  eth_rx_slot #(.SLOT_ADDR_W(SLOT_ADDR_W)) i_eth_rx_slot (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .gmii_rxd_i   (gmii_rxd_i),
    .gmii_rx_dv_i (gmii_rx_dv_i),
    .slot_busy_i  (slot_busy),
    .now_i        (count),
    .ram_addr_o   (b_addr),
    .ram_data_o   (b_data),
    .ram_be_o     (b_be),
    .ram_we_o     (b_we),
    .frame_done_o (frame_done),
    .frame_len_o  (frame_len),
    .timestamp_o  (timestamp)
  );

  slot_ram #(.SLOT_ADDR_W(SLOT_ADDR_W)) i_slot_ram (
    .clk_125  (clk_125),
    .a_addr_i (a_addr),
    .a_data_i (a_data),
    .a_be_i   (a_be),
    .a_we_i   (a_we),
    .a_q_o    (a_q),
    .b_addr_i (b_addr),
    .b_data_i (b_data),
    .b_be_i   (b_be),
    .b_we_i   (b_we),
    .b_q_o    ()
  );

  host_bus_regs #(.SLOT_ADDR_W(SLOT_ADDR_W)) i_host_bus_regs (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .irq_o        (irq_o),
    .cnt_wr_o     (cnt_wr),
    .cnt_word_o   (cnt_word),
    .cnt_sel_o    (cnt_sel),
    .cnt_data_o   (cnt_data),
    .slot_busy_o  (slot_busy),
    .count_i      (count),
    .frame_done_i (frame_done),
    .frame_len_i  (frame_len),
    .timestamp_i  (timestamp),
    .ram_addr_o   (a_addr),
    .ram_data_o   (a_data),
    .ram_be_o     (a_be),
    .ram_we_o     (a_we),
    .ram_q_i      (a_q)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #5;
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== dv/capture_chk.sv ====
`default_nettype none

module capture_chk import capture_pkg::*; (
  input logic                clk_125,
  input logic                core_rst_n,
  input logic [WB_ADR_W-1:0] wb_adr_i,
  input logic                wb_we_i,
  input logic                wb_cyc_i,
  input logic                wb_stb_i,
  input logic                wb_ack_o,
  input logic                irq_o,
  input logic                frame_done_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic req;
  logic req_q;
  logic req_start;
  logic slot_rd;
  logic ack_pulse_err = 1'b0;
  logic reg_ack_err   = 1'b0;
  logic slot_ack_err  = 1'b0;
  logic irq_reset_err = 1'b0;
  logic irq_rise_err  = 1'b0;
  logic failed;

  assign req       = wb_cyc_i && wb_stb_i;
  // host always drops stb between requests
  assign req_start = req && !req_q;
  assign slot_rd   = (wb_adr_i[15:13] == REGION_RX) && (wb_adr_i[12:1] >= RX_SLOT_FIRST) &&
                     !wb_we_i;

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // --------------------------------------------------------------------------
  // bus timing
  // --------------------------------------------------------------------------
  ack_pulse: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    wb_ack_o |=> !wb_ack_o)
  else begin
    ack_pulse_err = 1'b1;
    $error("wb_ack_o high for two cycles in a row");
  end

  reg_ack: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    req_start && !slot_rd |=> wb_ack_o)
  else begin
    reg_ack_err = 1'b1;
    $error("register or write request not acked on the next cycle");
  end

  slot_ack: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    req_start && slot_rd |=> !wb_ack_o ##1 !wb_ack_o ##1 wb_ack_o)
  else begin
    slot_ack_err = 1'b1;
    $error("slot read not acked exactly three cycles after the request");
  end

  // --------------------------------------------------------------------------
  // interrupt
  // --------------------------------------------------------------------------
  irq_reset: assert property (@(posedge clk_125)
    $rose(core_rst_n) |-> !irq_o && !wb_ack_o)
  else begin
    irq_reset_err = 1'b1;
    $error("irq_o or wb_ack_o high after reset");
  end

  irq_rise: assert property (@(posedge clk_125) disable iff (!core_rst_n)
    $rose(irq_o) |-> $past(frame_done_i))
  else begin
    irq_rise_err = 1'b1;
    $error("irq_o rose without frame_done one cycle before");
  end

  assign failed = ack_pulse_err || reg_ack_err || slot_ack_err || irq_reset_err ||
                  irq_rise_err;

endmodule

bind host_bus_regs capture_chk i_chk (
  .clk_125      (clk_125),
  .core_rst_n   (core_rst_n),
  .wb_adr_i     (wb_adr_i),
  .wb_we_i      (wb_we_i),
  .wb_cyc_i     (wb_cyc_i),
  .wb_stb_i     (wb_stb_i),
  .wb_ack_o     (wb_ack_o),
  .irq_o        (irq_o),
  .frame_done_i (frame_done_i)
);

`default_nettype wire

// ==== dv/capture_tb.sv ====
`default_nettype none

module capture_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // four frames and three slot dumps stay well under 4000 cycles
  localparam int TIMEOUT_CYCLES = 20000;

  localparam logic [15:0] ADR_STATUS = 16'h0000;
  localparam logic [15:0] ADR_CNT3   = 16'h000A;
  localparam logic [15:0] ADR_TS3    = 16'h8006;
  localparam logic [15:0] ADR_LEN    = 16'h800C;
  localparam logic [15:0] ADR_SLOT   = 16'h8010;
  localparam logic [15:0] TS3_VALUE  = 16'hC0DE;
  localparam logic [7:0]  SFD_BYTE   = 8'hD5;
  // unmapped regions and reserved indices
  localparam logic [15:0] UNMAPPED [7] = '{16'h2000, 16'hE002, 16'h0002, 16'h000C,
                                           16'h0010, 16'h8008, 16'h800E};

  logic        clk_125;
  logic        core_rst_n;
  logic [7:0]  gmii_rxd;
  logic        gmii_rx_dv;
  logic [15:0] wb_adr;
  logic [15:0] wb_dat_w;
  logic [1:0]  wb_sel;
  logic        wb_we;
  logic        wb_cyc;
  logic        wb_stb;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic        irq;

  logic [31:0] lcg_state;
  logic [7:0]  tx_bytes  [256];
  logic [7:0]  exp_bytes [256];
  int          cycle_cnt = 0;

  tb_clk_gen i_clk_gen (
    .clk_o (clk_125)
  );

  capture_top i_dut (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .gmii_rxd_i   (gmii_rxd),
    .gmii_rx_dv_i (gmii_rx_dv),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_sel_i     (wb_sel),
    .wb_we_i      (wb_we),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .irq_o        (irq)
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic next_cycle();
    @(posedge clk_125);
    #1;
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp, input logic [15:0] mask);
    assert ((got & mask) === (exp & mask))
    else fail_run($sformatf("ERROR: %0t ns: %s read 0x%h, expected 0x%h",
                            $time, what, got, exp));
  endtask

  task automatic write_bus(input logic [15:0] adr, input logic [1:0] sel,
                           input logic [15:0] data);
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = data;
    wb_we    = 1'b1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    next_cycle();
    while (!wb_ack) begin
      next_cycle();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // stb low for a cycle between requests
    next_cycle();
  endtask

  task automatic read_bus(input logic [15:0] adr, output logic [15:0] data);
    wb_adr = adr;
    wb_sel = 2'b11;
    wb_we  = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    next_cycle();
    while (!wb_ack) begin
      next_cycle();
    end
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    next_cycle();
  endtask

  task automatic draw_length(output int n);
    lcg_state = next_random(lcg_state);
    n = 1 + int'(lcg_state[30:23]) % 200;
  endtask

  task automatic send_frame(input int n_pre, input bit with_sfd, input int n_data);
    gmii_rx_dv = 1'b1;
    for (int i = 0; i < n_pre; i++) begin
      gmii_rxd = 8'h55;
      next_cycle();
    end
    if (with_sfd) begin
      gmii_rxd = SFD_BYTE;
      next_cycle();
    end
    for (int i = 0; i < n_data; i++) begin
      lcg_state   = next_random(lcg_state);
      tx_bytes[i] = lcg_state[23:16];
      gmii_rxd    = tx_bytes[i];
      next_cycle();
    end
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    next_cycle();
  endtask

  task automatic wait_irq();
    while (!irq) begin
      next_cycle();
    end
  endtask

  // byte k sits in word k/4, lane k mod 4, lane 0 in bits 7:0
  task automatic verify_capture(input int n);
    logic [15:0] rd;
    logic [15:0] mask;
    read_bus(ADR_LEN, rd);
    check_value("frame length", rd, 16'(n), 16'hFFFF);
    read_bus(ADR_TS3, rd);
    check_value("timestamp bits 63:48", rd, TS3_VALUE, 16'hFFFF);
    for (int h = 0; h < (n + 1) / 2; h++) begin
      mask = (2 * h + 1 < n) ? 16'hFFFF : 16'h00FF;
      read_bus(ADR_SLOT + 16'(2 * h), rd);
      check_value($sformatf("slot halfword %0d", h), rd,
                  {exp_bytes[2 * h + 1], exp_bytes[2 * h]}, mask);
    end
  endtask

  always @(posedge clk_125) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("simulation timed out after %0d cycles", TIMEOUT_CYCLES));
    end
    if (i_dut.i_host_bus_regs.i_chk.failed) begin
      fail_run("a bound bus or interrupt assertion failed");
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [15:0] rd;
    int          n_a;
    int          n_b;
    int          n_c;

    lcg_state  = 32'd54252;
    core_rst_n = 1'b0;
    gmii_rxd   = 8'h00;
    gmii_rx_dv = 1'b0;
    wb_adr     = 16'h0000;
    wb_dat_w   = 16'h0000;
    wb_sel     = 2'b00;
    wb_we      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    repeat (2) @(posedge clk_125);
    #1;
    core_rst_n = 1'b1;
    next_cycle();

    // reset state and address map holes
    read_bus(ADR_STATUS, rd);
    check_value("status after reset", rd, 16'h0000, 16'hFFFF);
    check_value("irq after reset", {15'd0, irq}, 16'h0000, 16'hFFFF);
    write_bus(16'h2000, 2'b11, 16'hFFFF);
    foreach (UNMAPPED[i]) begin
      read_bus(UNMAPPED[i], rd);
      check_value($sformatf("unmapped 0x%h", UNMAPPED[i]), rd, 16'h0000, 16'hFFFF);
    end
    write_bus(ADR_STATUS, 2'b11, 16'h000E);
    read_bus(ADR_STATUS, rd);
    check_value("status scratch bits", rd, 16'h000E, 16'hFFFF);
    write_bus(ADR_STATUS, 2'b11, 16'h0000);

    // wall clock lanes, sel[0] is bits 15:8
    write_bus(ADR_CNT3, 2'b11, 16'h1234);
    read_bus(ADR_CNT3, rd);
    check_value("cnt3 both lanes", rd, 16'h1234, 16'hFFFF);
    write_bus(ADR_CNT3, 2'b01, 16'hABCD);
    read_bus(ADR_CNT3, rd);
    check_value("cnt3 upper lane", rd, 16'hAB34, 16'hFFFF);
    write_bus(ADR_CNT3, 2'b10, 16'h5566);
    read_bus(ADR_CNT3, rd);
    check_value("cnt3 lower lane", rd, 16'hAB66, 16'hFFFF);
    write_bus(ADR_CNT3, 2'b11, TS3_VALUE);

    // first frame is captured
    draw_length(n_a);
    send_frame(7, 1'b1, n_a);
    wait_irq();
    exp_bytes = tx_bytes;
    read_bus(ADR_STATUS, rd);
    check_value("frame ready", rd, 16'h0001, 16'hFFFF);
    verify_capture(n_a);

    // slot still full, frame dropped
    draw_length(n_b);
    send_frame(7, 1'b1, n_b);
    repeat (4) next_cycle();
    verify_capture(n_a);

    write_bus(ADR_STATUS, 2'b11, 16'h0000);
    check_value("irq after status clear", {15'd0, irq}, 16'h0000, 16'hFFFF);

    // dv falls before the SFD
    send_frame(5, 1'b0, 0);
    repeat (4) next_cycle();
    check_value("irq after aborted frame", {15'd0, irq}, 16'h0000, 16'hFFFF);
    read_bus(ADR_STATUS, rd);
    check_value("status after aborted frame", rd, 16'h0000, 16'hFFFF);

    draw_length(n_c);
    send_frame(7, 1'b1, n_c);
    wait_irq();
    exp_bytes = tx_bytes;
    verify_capture(n_c);

    if (i_dut.i_host_bus_regs.i_chk.failed) begin
      fail_run("a bound bus or interrupt assertion failed");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/capture_pkg.sv
design/wall_clock.sv
design/eth_rx_slot.sv
design/slot_ram.sv
design/host_bus_regs.sv
design/capture_top.sv
dv/tb_clk_gen.sv
dv/capture_chk.sv
dv/capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module capture_tb -f vlog.f -o capture_sim

./obj_dir/capture_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log
